// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_harmonics
RTL_TOP = harmonics_top
FILELIST = vlog.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/harmonics_pkg.sv ====
`default_nettype none

package harmonics_pkg;

	localparam int DATA_W = 18;
	localparam int FRAC_W = 14;
	localparam int ADDR_W = 9;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic [2:0] {
		IDLE,
		PREDICT,
		SUM_STORE,
		ERROR,
		CORRECT,
		NEXT_CHAN
	} phase_e;

	typedef enum logic [2:0] {
		NOP,
		LOAD_MUL,
		ADD_MUL,
		SUB_MUL,
		ADD_OPERAND,
		SUB_FROM_OPERAND
	} mac_op_e;

	localparam int COEF_PER_HARM = 4;
	localparam int STATE_PER_HARM = 2;

	// pointer top bit selects the common area of a memory
	localparam addr_t PTR_COMMON = addr_t'(1) << (ADDR_W - 1);
	localparam addr_t ST_X1 = addr_t'(0);
	localparam addr_t ST_X2 = addr_t'(1);
	localparam addr_t ST_SUM = PTR_COMMON;
	localparam addr_t ST_ERR = PTR_COMMON | addr_t'(1);
	localparam addr_t CF_COS = addr_t'(0);
	localparam addr_t CF_SIN = addr_t'(1);
	localparam addr_t CF_K1 = addr_t'(2);
	localparam addr_t CF_K2 = addr_t'(3);
	localparam addr_t CF_INPUT = PTR_COMMON;

endpackage

`default_nettype wire

// ==== common/mac_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one micro-instruction per cycle, no handshake
interface mac_ctrl_if;
	import harmonics_pkg::*;

	mac_op_e op;
	logic valid;
	logic wr_en;
	addr_t dest_addr;

	modport seq (
		output op, valid, wr_en, dest_addr
	);

	modport mac (
		input op, valid, wr_en, dest_addr
	);

endinterface

`default_nettype wire

// ==== datapath/mac_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
	input  logic                 clk,
	input  logic                 harmonics_rst,
	mac_ctrl_if.mac              ctrl,
	input  harmonics_pkg::data_t state_i,
	input  harmonics_pkg::data_t coef_i,
	output harmonics_pkg::data_t result_o
);
	import harmonics_pkg::*;

	localparam int PROD_W = 2 * DATA_W;
	localparam int ACC_W = PROD_W + 4;

	mac_op_e op_q;
	logic valid_q;
	logic signed [PROD_W-1:0] prod;
	logic signed [ACC_W-1:0] prod_ext, state_ext, coef_ext, acc_d, acc_q, acc_shift;

	// instruction arrives one cycle ahead of the registered memory data
	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			op_q <= NOP;
			valid_q <= 1'b0;
		end else begin
			op_q <= ctrl.op;
			valid_q <= ctrl.valid;
		end
	end

	assign prod = state_i * coef_i;
	assign prod_ext = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};
	assign state_ext = {{(ACC_W-DATA_W){state_i[DATA_W-1]}}, state_i};
	assign coef_ext = {{(ACC_W-DATA_W){coef_i[DATA_W-1]}}, coef_i};

	// accumulator keeps full precision and is scaled only on the way out
	always_comb begin
		case (op_q)
			LOAD_MUL:         acc_d = prod_ext;
			ADD_MUL:          acc_d = acc_q + prod_ext;
			SUB_MUL:          acc_d = acc_q - prod_ext;
			ADD_OPERAND:      acc_d = acc_q + (state_ext <<< FRAC_W);
			SUB_FROM_OPERAND: acc_d = (coef_ext <<< FRAC_W) - acc_q;
			default:          acc_d = acc_q;
		endcase
		// a bubble clears the accumulator before a sum
		if (!valid_q) begin
			acc_d = '0;
		end
	end

	always_ff @(posedge clk) begin
		acc_q <= acc_d;
	end

	assign acc_shift = acc_q >>> FRAC_W;
	assign result_o = acc_shift[DATA_W-1:0];

endmodule

`default_nettype wire

// ==== design/dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
	parameter int DEPTH = 512
) (
	input  logic                 clk,
	input  logic                 we_i,
	input  harmonics_pkg::addr_t waddr_i,
	input  harmonics_pkg::data_t wdata_i,
	input  harmonics_pkg::addr_t raddr_i,
	output harmonics_pkg::data_t rdata_o
);

	harmonics_pkg::data_t mem [DEPTH];

	// read returns the old word when both ports hit the same address
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_o <= mem[raddr_i];
	end

endmodule

`default_nettype wire

// ==== design/harmonics_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module harmonics_top #(
	parameter int HARMONICS_NUM = 4,
	parameter int IN_SERIES_NUM = 2
) (
	input  logic                 clk,
	input  logic                 harmonics_rst,
	input  logic                 start_i,
	input  logic                 load_we_i,
	input  logic                 load_sel_i,
	input  harmonics_pkg::addr_t load_addr_i,
	input  harmonics_pkg::data_t load_data_i,
	output logic                 busy_o,
	output logic                 st_we_o,
	output harmonics_pkg::addr_t st_addr_o,
	output harmonics_pkg::data_t st_data_o
);
	import harmonics_pkg::*;

	localparam int CHAN_W = (IN_SERIES_NUM > 1) ? $clog2(IN_SERIES_NUM) : 1;
	localparam int OFF_W = ADDR_W - CHAN_W;

	mac_ctrl_if ctrl_if ();

	logic st_rd_step, st_rd_rewind, st_wr_step, st_wr_rewind, cf_rd_step, cf_rd_rewind;
	addr_t st_rd_ptr, st_wr_ptr, cf_rd_ptr;
	addr_t st_rd_addr, st_wr_addr, cf_rd_addr;
	logic [CHAN_W-1:0] chan;
	addr_t st_raddr, wr_addr_early;
	logic [ADDR_W:0] wr_pipe;
	data_t st_rdata, cf_rdata, mac_result;
	logic load_st;

	harmonics_sequencer #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM),
		.CHAN_W(CHAN_W)
	) u_seq (
		.clk(clk), .harmonics_rst(harmonics_rst), .start_i(start_i), .busy_o(busy_o),
		.ctrl(ctrl_if.seq),
		.st_rd_step_o(st_rd_step), .st_rd_rewind_o(st_rd_rewind), .st_rd_ptr_o(st_rd_ptr),
		.st_wr_step_o(st_wr_step), .st_wr_rewind_o(st_wr_rewind), .st_wr_ptr_o(st_wr_ptr),
		.cf_rd_step_o(cf_rd_step), .cf_rd_rewind_o(cf_rd_rewind), .cf_rd_ptr_o(cf_rd_ptr),
		.chan_o(chan)
	);

	addr_gen #(.STRIDE(STATE_PER_HARM), .COMMON_BASE(STATE_PER_HARM * HARMONICS_NUM),
		.ADDR_W(ADDR_W)) u_st_rd_gen (
		.clk(clk), .harmonics_rst(harmonics_rst), .step_i(st_rd_step),
		.rewind_i(st_rd_rewind), .ptr_i(st_rd_ptr), .addr_o(st_rd_addr)
	);

	addr_gen #(.STRIDE(STATE_PER_HARM), .COMMON_BASE(STATE_PER_HARM * HARMONICS_NUM),
		.ADDR_W(ADDR_W)) u_st_wr_gen (
		.clk(clk), .harmonics_rst(harmonics_rst), .step_i(st_wr_step),
		.rewind_i(st_wr_rewind), .ptr_i(st_wr_ptr), .addr_o(st_wr_addr)
	);

	addr_gen #(.STRIDE(COEF_PER_HARM), .COMMON_BASE(COEF_PER_HARM * HARMONICS_NUM),
		.ADDR_W(ADDR_W)) u_cf_rd_gen (
		.clk(clk), .harmonics_rst(harmonics_rst), .step_i(cf_rd_step),
		.rewind_i(cf_rd_rewind), .ptr_i(cf_rd_ptr), .addr_o(cf_rd_addr)
	);

	// channel index forms the upper bits of every state address
	assign st_raddr = {chan, st_rd_addr[OFF_W-1:0]};
	assign wr_addr_early = {ctrl_if.dest_addr[ADDR_W-1:OFF_W], st_wr_addr[OFF_W-1:0]};

	pipe_delay #(.WIDTH(ADDR_W + 1), .CYCLES(2)) u_wr_delay (
		.clk(clk), .harmonics_rst(harmonics_rst),
		.in_i({ctrl_if.wr_en, wr_addr_early}), .out_o(wr_pipe)
	);

	assign st_we_o = wr_pipe[ADDR_W];
	assign st_addr_o = wr_pipe[ADDR_W-1:0];
	assign st_data_o = mac_result;
	assign load_st = load_we_i & load_sel_i;

	dp_ram #(.DEPTH(2 ** ADDR_W)) u_st_ram (
		.clk(clk), .we_i(st_we_o | load_st),
		.waddr_i(load_st ? load_addr_i : st_addr_o),
		.wdata_i(load_st ? load_data_i : mac_result),
		.raddr_i(st_raddr), .rdata_o(st_rdata)
	);

	dp_ram #(.DEPTH(2 ** ADDR_W)) u_cf_ram (
		.clk(clk), .we_i(load_we_i & ~load_sel_i), .waddr_i(load_addr_i),
		.wdata_i(load_data_i), .raddr_i(cf_rd_addr), .rdata_o(cf_rdata)
	);

	mac_unit u_mac (
		.clk(clk), .harmonics_rst(harmonics_rst), .ctrl(ctrl_if.mac),
		.state_i(st_rdata), .coef_i(cf_rdata), .result_o(mac_result)
	);

endmodule

`default_nettype wire

// ==== design/pipe_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
	parameter int WIDTH = 1,
	parameter int CYCLES = 1
) (
	input  logic             clk,
	input  logic             harmonics_rst,
	input  logic [WIDTH-1:0] in_i,
	output logic [WIDTH-1:0] out_o
);

	logic [WIDTH-1:0] stage_q [CYCLES];

	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			for (int i = 0; i < CYCLES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_i;
			for (int i = 1; i < CYCLES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_o = stage_q[CYCLES-1];

endmodule

`default_nettype wire

// ==== sequencer/addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_gen #(
	parameter int STRIDE = 2,
	parameter int COMMON_BASE = 8,
	parameter int ADDR_W = 9
) (
	input  logic              clk,
	input  logic              harmonics_rst,
	input  logic              step_i,
	input  logic              rewind_i,
	input  logic [ADDR_W-1:0] ptr_i,
	output logic [ADDR_W-1:0] addr_o
);

	logic [ADDR_W-1:0] base_q;
	logic [ADDR_W-1:0] sel_base;

	assign sel_base = ptr_i[ADDR_W-1] ? COMMON_BASE[ADDR_W-1:0] : base_q;

	// rewind wins over step so the last harmonic can do both
	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			base_q <= '0;
			addr_o <= '0;
		end else begin
			if (rewind_i) begin
				base_q <= '0;
			end else if (step_i) begin
				base_q <= base_q + STRIDE[ADDR_W-1:0];
			end
			addr_o <= sel_base + {1'b0, ptr_i[ADDR_W-2:0]};
		end
	end

endmodule

`default_nettype wire

// ==== sequencer/harmonics_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module harmonics_sequencer #(
	parameter int HARMONICS_NUM = 4,
	parameter int IN_SERIES_NUM = 2,
	parameter int CHAN_W = 1
) (
	input  logic                 clk,
	input  logic                 harmonics_rst,
	input  logic                 start_i,
	output logic                 busy_o,
	mac_ctrl_if.seq              ctrl,
	output logic                 st_rd_step_o,
	output logic                 st_rd_rewind_o,
	output harmonics_pkg::addr_t st_rd_ptr_o,
	output logic                 st_wr_step_o,
	output logic                 st_wr_rewind_o,
	output harmonics_pkg::addr_t st_wr_ptr_o,
	output logic                 cf_rd_step_o,
	output logic                 cf_rd_rewind_o,
	output harmonics_pkg::addr_t cf_rd_ptr_o,
	output logic [CHAN_W-1:0]    chan_o
);
	import harmonics_pkg::*;

	localparam int HARM_W = (HARMONICS_NUM > 1) ? $clog2(HARMONICS_NUM) : 1;

	phase_e phase_q;
	logic [1:0] step_q;
	logic [HARM_W-1:0] harm_q;
	logic last_harm, last_chan;
	mac_op_e op_a;
	logic valid_a, wr_en_a;

	assign last_harm = (harm_q == HARM_W'(HARMONICS_NUM - 1));
	assign last_chan = (chan_o == CHAN_W'(IN_SERIES_NUM - 1));

	// second stage lines the instruction up with the generated addresses
	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			ctrl.op <= NOP;
			ctrl.valid <= 1'b0;
			ctrl.wr_en <= 1'b0;
			ctrl.dest_addr <= '0;
		end else begin
			ctrl.op <= op_a;
			ctrl.valid <= valid_a;
			ctrl.wr_en <= wr_en_a;
			ctrl.dest_addr <= {chan_o, {(ADDR_W-CHAN_W){1'b0}}};
		end
	end

	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			phase_q <= IDLE;
			step_q <= '0;
			harm_q <= '0;
			chan_o <= '0;
			busy_o <= 1'b0;
			op_a <= NOP;
			valid_a <= 1'b0;
			wr_en_a <= 1'b0;
			{st_rd_step_o, st_rd_rewind_o, st_wr_step_o} <= '0;
			{st_wr_rewind_o, cf_rd_step_o, cf_rd_rewind_o} <= '0;
			st_rd_ptr_o <= '0;
			st_wr_ptr_o <= '0;
			cf_rd_ptr_o <= '0;
		end else begin
			op_a <= NOP;
			valid_a <= 1'b0;
			wr_en_a <= 1'b0;
			{st_rd_step_o, st_rd_rewind_o, st_wr_step_o} <= '0;
			{st_wr_rewind_o, cf_rd_step_o, cf_rd_rewind_o} <= '0;
			st_rd_ptr_o <= '0;
			st_wr_ptr_o <= '0;
			cf_rd_ptr_o <= '0;
			step_q <= step_q + 2'd1;
			case (phase_q)
				IDLE: begin
					step_q <= '0;
					if (start_i) begin
						busy_o <= 1'b1;
						harm_q <= '0;
						chan_o <= '0;
						phase_q <= PREDICT;
					end
				end
				PREDICT: begin
					valid_a <= 1'b1;
					case (step_q)
						2'd0: begin
							op_a <= LOAD_MUL;
							st_rd_ptr_o <= ST_X1;
							cf_rd_ptr_o <= CF_COS;
						end
						2'd1: begin
							op_a <= SUB_MUL;
							st_rd_ptr_o <= ST_X2;
							cf_rd_ptr_o <= CF_SIN;
							wr_en_a <= 1'b1;
							st_wr_ptr_o <= ST_X1;
						end
						2'd2: begin
							op_a <= LOAD_MUL;
							st_rd_ptr_o <= ST_X1;
							cf_rd_ptr_o <= CF_SIN;
						end
						default: begin
							op_a <= ADD_MUL;
							st_rd_ptr_o <= ST_X2;
							cf_rd_ptr_o <= CF_COS;
							wr_en_a <= 1'b1;
							st_wr_ptr_o <= ST_X2;
							{st_rd_step_o, st_wr_step_o, cf_rd_step_o} <= '1;
							{st_rd_rewind_o, st_wr_rewind_o, cf_rd_rewind_o} <= {3{last_harm}};
							harm_q <= last_harm ? '0 : harm_q + 1'b1;
							if (last_harm) begin
								phase_q <= SUM_STORE;
							end
						end
					endcase
				end
				SUM_STORE: begin
					// step 0 is a bubble, then one add per new x1
					if (step_q != 2'd0) begin
						step_q <= step_q;
						valid_a <= 1'b1;
						op_a <= ADD_OPERAND;
						st_rd_ptr_o <= ST_X1;
						st_rd_step_o <= 1'b1;
						harm_q <= last_harm ? '0 : harm_q + 1'b1;
						if (last_harm) begin
							st_rd_rewind_o <= 1'b1;
							wr_en_a <= 1'b1;
							st_wr_ptr_o <= ST_SUM;
							step_q <= '0;
							phase_q <= ERROR;
						end
					end
				end
				ERROR: begin
					// two idle steps let the error land before CORRECT reads it
					if (step_q == 2'd0) begin
						valid_a <= 1'b1;
						op_a <= SUB_FROM_OPERAND;
						cf_rd_ptr_o <= CF_INPUT | addr_t'(chan_o);
						wr_en_a <= 1'b1;
						st_wr_ptr_o <= ST_ERR;
					end else if (step_q == 2'd2) begin
						step_q <= '0;
						phase_q <= CORRECT;
					end
				end
				CORRECT: begin
					valid_a <= 1'b1;
					case (step_q)
						2'd0: begin
							op_a <= LOAD_MUL;
							st_rd_ptr_o <= ST_ERR;
							cf_rd_ptr_o <= CF_K1;
						end
						2'd1: begin
							op_a <= ADD_OPERAND;
							st_rd_ptr_o <= ST_X1;
							wr_en_a <= 1'b1;
							st_wr_ptr_o <= ST_X1;
						end
						2'd2: begin
							op_a <= LOAD_MUL;
							st_rd_ptr_o <= ST_ERR;
							cf_rd_ptr_o <= CF_K2;
						end
						default: begin
							op_a <= ADD_OPERAND;
							st_rd_ptr_o <= ST_X2;
							wr_en_a <= 1'b1;
							st_wr_ptr_o <= ST_X2;
							{st_rd_step_o, st_wr_step_o, cf_rd_step_o} <= '1;
							{st_rd_rewind_o, st_wr_rewind_o, cf_rd_rewind_o} <= {3{last_harm}};
							harm_q <= last_harm ? '0 : harm_q + 1'b1;
							if (last_harm) begin
								phase_q <= NEXT_CHAN;
							end
						end
					endcase
				end
				NEXT_CHAN: begin
					// wait for the last write to leave the pipeline
					if (step_q == 2'd3) begin
						if (last_chan) begin
							busy_o <= 1'b0;
							phase_q <= IDLE;
						end else begin
							chan_o <= chan_o + 1'b1;
							phase_q <= PREDICT;
						end
					end
				end
				default: begin
					phase_q <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== test/harmonics_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module harmonics_assertions (
	input  logic                   clk,
	input  logic                   harmonics_rst,
	input  logic                   start_i,
	input  logic                   busy_i,
	input  harmonics_pkg::phase_e  phase_i,
	input  logic                   last_chan_i,
	input  logic                   wr_en_i
);
	import harmonics_pkg::*;

	// st_we_o is the first-stage write enable three cycles later
	a_write_in_run: assert property (@(posedge clk) disable iff (harmonics_rst)
		$past(wr_en_i, 3) |-> busy_i)
		else $error("output write seen while busy_o is low");

	a_busy_fall: assert property (@(posedge clk) disable iff (harmonics_rst)
		$fell(busy_i) |-> ($past(phase_i) == NEXT_CHAN) && $past(last_chan_i))
		else $error("busy_o fell outside NEXT_CHAN of the last channel");

	a_busy_rise: assert property (@(posedge clk) disable iff (harmonics_rst)
		$rose(busy_i) |-> $past(start_i))
		else $error("busy_o rose without a start pulse");

endmodule

bind harmonics_sequencer harmonics_assertions u_assert (
	.clk(clk),
	.harmonics_rst(harmonics_rst),
	.start_i(start_i),
	.busy_i(busy_o),
	.phase_i(phase_q),
	.last_chan_i(last_chan),
	.wr_en_i(wr_en_a)
);

`default_nettype wire

// ==== test/tb_harmonics.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_harmonics;
	import harmonics_pkg::*;

	localparam int H = 4;
	localparam int S = 2;
	localparam int CLK_PERIOD = 100;
	localparam int NROWS = 5;
	localparam int NSTATE = STATE_PER_HARM * H;
	localparam int NCOEF = COEF_PER_HARM * H;
	localparam int CHAN_SHIFT = (S > 1) ? ADDR_W - $clog2(S) : ADDR_W - 1;
	localparam int WRITES_PER_CHAN = 4 * H + 2;
	localparam int WATCHDOG_CYCLES = NROWS * (20 * H * S + 50) + 10;

	logic clk;
	logic harmonics_rst;
	logic start;
	logic load_we;
	logic load_sel;
	addr_t load_addr;
	data_t load_data;
	logic busy;
	logic st_we;
	addr_t st_addr;
	data_t st_data;

	// one row per run
	string row_name [NROWS];
	bit row_load_state [NROWS];
	bit row_mid_start [NROWS];
	int row_exp_writes [NROWS];
	longint row_state [NROWS][S][NSTATE];
	longint row_coef [NROWS][NCOEF];
	longint row_input [NROWS][S];

	longint model_x [S][NSTATE];
	addr_t exp_addr [$];
	data_t exp_data [$];
	addr_t got_addr [$];
	data_t got_data [$];
	int unsigned lcg_state = 3359;
	int check_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	harmonics_top #(.HARMONICS_NUM(H), .IN_SERIES_NUM(S)) u_dut (
		.clk(clk), .harmonics_rst(harmonics_rst), .start_i(start), .load_we_i(load_we),
		.load_sel_i(load_sel), .load_addr_i(load_addr), .load_data_i(load_data),
		.busy_o(busy), .st_we_o(st_we), .st_addr_o(st_addr), .st_data_o(st_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("timeout: the runs did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (st_we) begin
			got_addr.push_back(st_addr);
			got_data.push_back(st_data);
		end
	end

	function automatic longint lcg_value(input int bits);
		logic [31:0] raw;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		raw = lcg_state >> 8;
		return longint'(signed'(raw << (32 - bits))) >>> (32 - bits);
	endfunction

	function automatic longint wrap_word(input longint v);
		data_t w;
		w = data_t'(v);
		return longint'(w);
	endfunction

	function automatic void expect_write(input addr_t a, input longint d);
		exp_addr.push_back(a);
		exp_data.push_back(data_t'(d));
	endfunction

	task automatic build_table();
		for (int r = 0; r < NROWS; r++) begin
			row_load_state[r] = (r < 3);
			row_mid_start[r] = (r == 4);
			row_exp_writes[r] = S * WRITES_PER_CHAN;
			for (int i = 0; i < NCOEF; i++) begin
				// row 1 keeps the gains at zero
				if (r == 0 || (r == 1 && (i % COEF_PER_HARM) >= 2)) begin
					row_coef[r][i] = 0;
				end else begin
					row_coef[r][i] = lcg_value(15);
				end
			end
			for (int c = 0; c < S; c++) begin
				row_input[r][c] = (r == 0) ? longint'(1000 - 3500 * c) : lcg_value(16);
				for (int k = 0; k < NSTATE; k++) begin
					row_state[r][c][k] = (r == 0) ? 0 : lcg_value(16);
				end
			end
		end
		row_name[0] = "zero coefficients and states";
		row_name[1] = "rotation with zero gains";
		row_name[2] = "full update with random values";
		row_name[3] = "two channels continuing from stored states";
		row_name[4] = "start pulse during busy";
	endtask

	task automatic model_run(input int r);
		longint x1, x2, nx1, nx2, sum, err, cs, sn, k1, k2;
		addr_t blk;
		exp_addr.delete();
		exp_data.delete();
		for (int c = 0; c < S; c++) begin
			blk = addr_t'(c << CHAN_SHIFT);
			if (row_load_state[r]) begin
				for (int k = 0; k < NSTATE; k++) begin
					model_x[c][k] = row_state[r][c][k];
				end
			end
			sum = 0;
			for (int h = 0; h < H; h++) begin
				x1 = model_x[c][2 * h];
				x2 = model_x[c][2 * h + 1];
				cs = row_coef[r][COEF_PER_HARM * h];
				sn = row_coef[r][COEF_PER_HARM * h + 1];
				nx1 = wrap_word((x1 * cs - x2 * sn) >>> FRAC_W);
				nx2 = wrap_word((x1 * sn + x2 * cs) >>> FRAC_W);
				model_x[c][2 * h] = nx1;
				model_x[c][2 * h + 1] = nx2;
				expect_write(blk + addr_t'(2 * h), nx1);
				expect_write(blk + addr_t'(2 * h + 1), nx2);
				sum = wrap_word(sum + nx1);
			end
			err = wrap_word(row_input[r][c] - sum);
			expect_write(blk + addr_t'(NSTATE), sum);
			expect_write(blk + addr_t'(NSTATE + 1), err);
			for (int h = 0; h < H; h++) begin
				k1 = row_coef[r][COEF_PER_HARM * h + 2];
				k2 = row_coef[r][COEF_PER_HARM * h + 3];
				model_x[c][2 * h] = wrap_word(model_x[c][2 * h] + ((k1 * err) >>> FRAC_W));
				model_x[c][2 * h + 1] = wrap_word(model_x[c][2 * h + 1] + ((k2 * err) >>> FRAC_W));
				expect_write(blk + addr_t'(2 * h), model_x[c][2 * h]);
				expect_write(blk + addr_t'(2 * h + 1), model_x[c][2 * h + 1]);
			end
		end
	endtask

	task automatic load_word(input logic sel, input addr_t a, input longint d);
		@(negedge clk);
		load_we = 1'b1;
		load_sel = sel;
		load_addr = a;
		load_data = data_t'(d);
	endtask

	task automatic load_row(input int r);
		for (int i = 0; i < NCOEF; i++) begin
			load_word(1'b0, addr_t'(i), row_coef[r][i]);
		end
		for (int c = 0; c < S; c++) begin
			load_word(1'b0, addr_t'(NCOEF + c), row_input[r][c]);
			for (int k = 0; k < NSTATE && row_load_state[r]; k++) begin
				load_word(1'b1, addr_t'((c << CHAN_SHIFT) + k), row_state[r][c][k]);
			end
		end
		@(negedge clk);
		load_we = 1'b0;
	endtask

	task automatic run_row(input int r);
		got_addr.delete();
		got_data.delete();
		load_row(r);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (!busy) begin
			@(negedge clk);
		end
		if (row_mid_start[r]) begin
			repeat (10) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (busy) begin
			@(negedge clk);
		end
		repeat (6) @(negedge clk);
	endtask

	task automatic check_row(input int r, output int errs);
		int n;
		int base;
		errs = 0;
		if (busy) begin
			$display("test %0d: busy_o did not return low after the run", r);
			errs++;
		end
		if (got_addr.size() != row_exp_writes[r]) begin
			$display("test %0d: expected %0d writes but saw %0d", r, row_exp_writes[r],
				got_addr.size());
			errs++;
		end
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			if (got_addr[i] !== exp_addr[i]) begin
				$display("[FAIL] st_addr_o test %0d write %0d: got %h expected %h", r, i,
					got_addr[i], exp_addr[i]);
				errs++;
			end
			if (got_data[i] !== exp_data[i]) begin
				$display("[FAIL] st_data_o test %0d write %0d: got %h expected %h", r, i,
					got_data[i], exp_data[i]);
				errs++;
			end
		end
		// zero gains leave the predicted states untouched
		if (r == 1 && n == row_exp_writes[r]) begin
			for (int c = 0; c < S; c++) begin
				base = c * WRITES_PER_CHAN;
				for (int k = 0; k < NSTATE; k++) begin
					if (got_data[base + NSTATE + 2 + k] !== exp_data[base + k]) begin
						$display("[FAIL] st_data_o test %0d chan %0d state %0d: got %h expected %h",
							r, c, k, got_data[base + NSTATE + 2 + k], exp_data[base + k]);
						errs++;
					end
				end
			end
		end
	endtask

	initial begin
		int errs;
		harmonics_rst = 1'b1;
		start = 1'b0;
		load_we = 1'b0;
		load_sel = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_table();
		repeat (5) @(negedge clk);
		harmonics_rst = 1'b0;
		if (busy || st_we) begin
			$display("busy_o or st_we_o is high right after reset");
			check_errors++;
		end
		for (int r = 0; r < NROWS; r++) begin
			model_run(r);
			run_row(r);
			check_row(r, errs);
			check_errors += errs;
			if (errs == 0) begin
				tests_passed++;
			end else begin
				tests_failed++;
			end
			$display("test %0d (%s): %s, %0d writes", r, row_name[r],
				(errs == 0) ? "ok" : "failed", got_addr.size());
		end
		$display("tests passed %0d, tests failed %0d, check errors %0d", tests_passed,
			tests_failed, check_errors);
		if (tests_failed == 0 && check_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/harmonics_pkg.sv
common/mac_ctrl_if.sv
design/pipe_delay.sv
design/dp_ram.sv
sequencer/addr_gen.sv
sequencer/harmonics_sequencer.sv
datapath/mac_unit.sv
design/harmonics_top.sv
test/harmonics_assertions.sv
test/tb_harmonics.sv
